//--- logic/noc_pkg.sv
// shared defaults and path state encoding for the tile network port
`default_nettype none

package noc_pkg;

    //////////////////////////////
    // default sizes
    //////////////////////////////

    // flit width in bits
    parameter int DEFAULT_DATA_WIDTH = 64;

    // flits the outbound path may have outstanding at the router
    parameter int DEFAULT_CREDITS = 4;

    // entries in the inbound queue
    parameter int DEFAULT_BUFFER_DEPTH = 4;

    //////////////////////////////
    // path state
    //////////////////////////////

    // open: a flit can be taken this cycle
    // blocked: sender out of credits, or buffer full
    typedef enum logic
    {
        PATH_OPEN    = 1'b0,
        PATH_BLOCKED = 1'b1
    } path_state_e;

endpackage : noc_pkg

`default_nettype wire

//--- logic/credit_sender.sv
// outbound path: takes valid/ready flits and sends them to the router under credit control
`timescale 1ns/10ps
`default_nettype none

module credit_sender #(
    parameter int DATA_WIDTH = noc_pkg::DEFAULT_DATA_WIDTH,
    parameter int CREDITS    = noc_pkg::DEFAULT_CREDITS
) (
    input  wire                   clk,
    input  wire                   reset,

    // processor side, valid/ready
    input  wire  [DATA_WIDTH-1:0] data_in,
    input  wire                   valid_in,
    output logic                  ready_in,

    // credit return from the router
    input  wire                   yummy_in,

    // router side, plain valid strobe
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  valid_out
);

    localparam int CNT_W = $clog2(CREDITS + 1);
    localparam logic [CNT_W-1:0] CREDIT_MAX = CNT_W'(CREDITS);

    logic [CNT_W-1:0]    credit_cnt;
    logic [CNT_W-1:0]    credit_cnt_next;
    noc_pkg::path_state_e state;
    noc_pkg::path_state_e state_next;
    logic                accept;

    //////////////////////////////
    // handshake
    //////////////////////////////

    // ready straight from the state flop, so no path from yummy to ready
    assign ready_in = (state == noc_pkg::PATH_OPEN);
    assign accept   = valid_in && ready_in;

    //////////////////////////////
    // credit counter
    //////////////////////////////

    // accept and yummy together cancel out
    always_comb
    begin
        credit_cnt_next = credit_cnt;
        if (accept && !yummy_in)
        begin
            credit_cnt_next = credit_cnt - 1'b1;
        end
        else if (yummy_in && !accept)
        begin
            credit_cnt_next = credit_cnt + 1'b1;
        end
    end

    assign state_next = (credit_cnt_next == '0) ? noc_pkg::PATH_BLOCKED : noc_pkg::PATH_OPEN;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            credit_cnt <= CREDIT_MAX;
            state      <= noc_pkg::PATH_OPEN;
            valid_out  <= 1'b0;
        end
        else
        begin
            credit_cnt <= credit_cnt_next;
            state      <= state_next;
            // one-cycle strobe per accepted flit
            valid_out  <= accept;
        end
    end

    // flit register toward the router
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            data_out <= data_in;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // router returns no more credits than were handed out
    a_no_extra_yummy : assert property (
        @(posedge clk) disable iff (reset)
        !(yummy_in && credit_cnt == CREDIT_MAX)
    ) else $error("credit_sender: yummy with all credits already home");

    // processor holds an offered flit until it is taken
    a_valid_held : assert property (
        @(posedge clk) disable iff (reset)
        (valid_in && !ready_in) |=> valid_in
    ) else $error("credit_sender: valid_in dropped before acceptance");

endmodule : credit_sender

`default_nettype wire

//--- logic/flit_buffer.sv
// inbound path: queues router flits, serves them with valid/ready and returns yummy pulses
`timescale 1ns/10ps
`default_nettype none

module flit_buffer #(
    parameter int DATA_WIDTH   = noc_pkg::DEFAULT_DATA_WIDTH,
    parameter int BUFFER_DEPTH = noc_pkg::DEFAULT_BUFFER_DEPTH
) (
    input  wire                   clk,
    input  wire                   reset,

    // router side, plain valid strobe
    input  wire  [DATA_WIDTH-1:0] data_in,
    input  wire                   valid_in,
    output logic                  yummy_out,

    // processor side, valid/ready
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  valid_out,
    input  wire                   ready_out
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH);
    localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT  = PTR_W'(BUFFER_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(BUFFER_DEPTH);

    logic [DATA_WIDTH-1:0] mem [BUFFER_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic [CNT_W-1:0]      count_next;
    noc_pkg::path_state_e  state;
    noc_pkg::path_state_e  state_next;
    logic                  push;
    logic                  pop;

    //////////////////////////////
    // queue control
    //////////////////////////////

    // a write into a full queue is dropped
    assign push = valid_in && (state == noc_pkg::PATH_OPEN);
    assign pop  = valid_out && ready_out;

    // head of queue shown whenever something is stored
    assign valid_out = (count != '0);
    assign data_out  = mem[rd_ptr];

    always_comb
    begin
        count_next = count;
        if (push && !pop)
        begin
            count_next = count + 1'b1;
        end
        else if (pop && !push)
        begin
            count_next = count - 1'b1;
        end
    end

    assign state_next = (count_next == FULL_COUNT) ? noc_pkg::PATH_BLOCKED : noc_pkg::PATH_OPEN;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            state     <= noc_pkg::PATH_OPEN;
            yummy_out <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count_next;
            state     <= state_next;
            // one credit back to the router per consumed flit
            yummy_out <= pop;
        end
    end

    //////////////////////////////
    // storage
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= data_in;
        end
    end

    // router keeps to its credits, so it never writes into a full queue
    a_no_write_when_full : assert property (
        @(posedge clk) disable iff (reset)
        valid_in |-> (state != noc_pkg::PATH_BLOCKED)
    ) else $error("flit_buffer: router wrote while the queue was full");

endmodule : flit_buffer

`default_nettype wire

//--- logic/noc_port.sv
// top level of the tile network port: outbound credit sender and inbound flit buffer
`timescale 1ns/10ps
`default_nettype none

module noc_port #(
    parameter int DATA_WIDTH   = noc_pkg::DEFAULT_DATA_WIDTH,
    parameter int CREDITS      = noc_pkg::DEFAULT_CREDITS,
    parameter int BUFFER_DEPTH = noc_pkg::DEFAULT_BUFFER_DEPTH
) (
    input  wire                   clk,
    input  wire                   reset,

    // outbound, processor side
    input  wire  [DATA_WIDTH-1:0] proc_out_data,
    input  wire                   proc_out_valid,
    output logic                  proc_out_ready,

    // outbound, router side
    output logic [DATA_WIDTH-1:0] net_out_data,
    output logic                  net_out_valid,
    input  wire                   net_out_yummy,

    // inbound, router side
    input  wire  [DATA_WIDTH-1:0] net_in_data,
    input  wire                   net_in_valid,
    output logic                  net_in_yummy,

    // inbound, processor side
    output logic [DATA_WIDTH-1:0] proc_in_data,
    output logic                  proc_in_valid,
    input  wire                   proc_in_ready
);

    //////////////////////////////
    // outbound path
    //////////////////////////////

    credit_sender #(
        .DATA_WIDTH (DATA_WIDTH),
        .CREDITS    (CREDITS)
    ) i_credit_sender (
        .clk       (clk),
        .reset     (reset),
        .data_in   (proc_out_data),
        .valid_in  (proc_out_valid),
        .ready_in  (proc_out_ready),
        .yummy_in  (net_out_yummy),
        .data_out  (net_out_data),
        .valid_out (net_out_valid)
    );

    //////////////////////////////
    // inbound path
    //////////////////////////////

    flit_buffer #(
        .DATA_WIDTH   (DATA_WIDTH),
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) i_flit_buffer (
        .clk       (clk),
        .reset     (reset),
        .data_in   (net_in_data),
        .valid_in  (net_in_valid),
        .yummy_out (net_in_yummy),
        .data_out  (proc_in_data),
        .valid_out (proc_in_valid),
        .ready_out (proc_in_ready)
    );

endmodule : noc_port

`default_nettype wire

//--- bench/noc_port_table.svh
// per-cycle stimulus and expected outputs for the noc_port testbench, included in its module
`ifndef NOC_PORT_TABLE_SVH
`define NOC_PORT_TABLE_SVH

// one hex digit per column, left to right
// stimulus: out_valid out_id out_yummy in_valid in_id in_ready
// expected: out_ready net_valid net_id proc_valid proc_id in_yummy
// ids pick a flit from the pool, 1..7 fixed patterns, 8..15 random
localparam int TABLE_LEN = 35;

localparam logic [47:0] ROWS [TABLE_LEN] = '{
    // idle after reset
    48'h0_0_0_0_0_0_1_0_0_0_0_0,
    // four flits with no credit return, fifth one held
    48'h1_1_0_0_0_0_1_0_0_0_0_0,
    48'h1_2_0_0_0_0_1_1_1_0_0_0,
    48'h1_3_0_0_0_0_1_1_2_0_0_0,
    48'h1_4_0_0_0_0_1_1_3_0_0_0,
    48'h1_5_0_0_0_0_0_1_4_0_0_0,
    48'h1_5_0_0_0_0_0_0_0_0_0_0,
    // yummy frees a credit, held flit goes out
    48'h1_5_1_0_0_0_0_0_0_0_0_0,
    48'h1_5_0_0_0_0_1_0_0_0_0_0,
    48'h0_0_1_0_0_0_0_1_5_0_0_0,
    48'h0_0_0_0_0_0_1_0_0_0_0_0,
    // accept and yummy together at one credit
    48'h1_6_1_0_0_0_1_0_0_0_0_0,
    48'h1_7_0_0_0_0_1_1_6_0_0_0,
    48'h0_0_1_0_0_0_0_1_7_0_0_0,
    48'h0_0_1_0_0_0_1_0_0_0_0_0,
    48'h0_0_1_0_0_0_1_0_0_0_0_0,
    48'h0_0_1_0_0_0_1_0_0_0_0_0,
    // inbound fill with processor stalled
    48'h0_0_0_1_1_0_1_0_0_0_0_0,
    48'h0_0_0_1_2_0_1_0_0_1_1_0,
    48'h0_0_0_1_3_0_1_0_0_1_1_0,
    48'h0_0_0_1_4_0_1_0_0_1_1_0,
    48'h0_0_0_0_0_0_1_0_0_1_1_0,
    // drain, one yummy per consumed flit
    48'h0_0_0_0_0_1_1_0_0_1_1_0,
    48'h0_0_0_0_0_1_1_0_0_1_2_1,
    48'h0_0_0_0_0_1_1_0_0_1_3_1,
    48'h0_0_0_0_0_1_1_0_0_1_4_1,
    48'h0_0_0_0_0_1_1_0_0_0_0_1,
    48'h0_0_0_0_0_0_1_0_0_0_0_0,
    // random flits both ways on the same cycles
    48'h1_8_0_1_c_1_1_0_0_0_0_0,
    48'h1_9_0_1_d_1_1_1_8_1_c_0,
    48'h1_a_1_1_e_1_1_1_9_1_d_1,
    48'h1_b_1_1_f_1_1_1_a_1_e_1,
    48'h0_0_1_0_0_1_1_1_b_1_f_1,
    48'h0_0_1_0_0_1_1_0_0_0_0_1,
    48'h0_0_0_0_0_1_1_0_0_0_0_0
};

`endif

//--- bench/noc_port_tb.sv
// testbench for noc_port: applies the table rows on falling edges and checks the outputs
`timescale 1ns/10ps
`default_nettype none

module noc_port_tb;

    localparam int DATA_WIDTH   = noc_pkg::DEFAULT_DATA_WIDTH;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;

    `include "noc_port_table.svh"

    localparam int CYCLE_LIMIT = TABLE_LEN + RESET_CYCLES + 20;

    logic                  clk;
    logic                  reset;
    logic [DATA_WIDTH-1:0] proc_out_data;
    logic                  proc_out_valid;
    logic                  proc_out_ready;
    logic [DATA_WIDTH-1:0] net_out_data;
    logic                  net_out_valid;
    logic                  net_out_yummy;
    logic [DATA_WIDTH-1:0] net_in_data;
    logic                  net_in_valid;
    logic                  net_in_yummy;
    logic [DATA_WIDTH-1:0] proc_in_data;
    logic                  proc_in_valid;
    logic                  proc_in_ready;

    // flits referenced by id from the table
    logic [DATA_WIDTH-1:0] flit_pool [16];
    integer                seed;
    int                    cycle_count;

    noc_port i_noc_port (
        .clk            (clk),
        .reset          (reset),
        .proc_out_data  (proc_out_data),
        .proc_out_valid (proc_out_valid),
        .proc_out_ready (proc_out_ready),
        .net_out_data   (net_out_data),
        .net_out_valid  (net_out_valid),
        .net_out_yummy  (net_out_yummy),
        .net_in_data    (net_in_data),
        .net_in_valid   (net_in_valid),
        .net_in_yummy   (net_in_yummy),
        .proc_in_data   (proc_in_data),
        .proc_in_valid  (proc_in_valid),
        .proc_in_ready  (proc_in_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_bit(input string name, input int row, input logic got,
                             input logic expected);
        assert (got === expected)
        else
        begin
            $display("Mismatch at %0t: row %0d, %s is %b, expected %b",
                     $time, row, name, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_flit(input string name, input int row,
                              input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] expected);
        assert (got === expected)
        else
        begin
            $display("Mismatch at %0t: row %0d, %s is %h, expected %h",
                     $time, row, name, got, expected);
            stop_with_failure();
        end
    endtask

    // fixed patterns first, then the random ids
    task automatic fill_pool();
        flit_pool[0] = '0;
        for (int i = 1; i < 8; i++)
        begin
            flit_pool[i] = {(DATA_WIDTH / 8){4'(i), 4'(15 - i)}};
        end
        for (int i = 8; i < 16; i++)
        begin
            flit_pool[i] = DATA_WIDTH'({$random(seed), $random(seed)});
        end
    endtask

    task automatic drive_row(input int r);
        logic [47:0] row;
        row            = ROWS[r];
        proc_out_valid = row[44];
        proc_out_data  = flit_pool[row[43:40]];
        net_out_yummy  = row[36];
        net_in_valid   = row[32];
        net_in_data    = flit_pool[row[31:28]];
        proc_in_ready  = row[24];
    endtask

    // data only compared while its valid is expected high
    task automatic check_row(input int r);
        logic [47:0] row;
        row = ROWS[r];
        check_bit("proc_out_ready", r, proc_out_ready, row[20]);
        check_bit("net_out_valid", r, net_out_valid, row[16]);
        if (row[16])
        begin
            check_flit("net_out_data", r, net_out_data, flit_pool[row[15:12]]);
        end
        check_bit("proc_in_valid", r, proc_in_valid, row[8]);
        if (row[8])
        begin
            check_flit("proc_in_data", r, proc_in_data, flit_pool[row[7:4]]);
        end
        check_bit("net_in_yummy", r, net_in_yummy, row[0]);
    endtask

    //////////////////////////////
    // timeout
    //////////////////////////////

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: table not finished within %0d cycles", CYCLE_LIMIT);
            stop_with_failure();
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        clk            = 1'b0;
        reset          = 1'b1;
        proc_out_data  = '0;
        proc_out_valid = 1'b0;
        net_out_yummy  = 1'b0;
        net_in_data    = '0;
        net_in_valid   = 1'b0;
        proc_in_ready  = 1'b0;
        cycle_count    = 0;
        seed           = 32'hf645_67eb;
        fill_pool();

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // sample one ns before the rising edge
        for (int r = 0; r < TABLE_LEN; r++)
        begin
            @(negedge clk);
            drive_row(r);
            #(CLK_PERIOD / 2 - 1);
            check_row(r);
        end

        @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule : noc_port_tb

`default_nettype wire

//--- all.f
+incdir+bench
logic/noc_pkg.sv
logic/credit_sender.sv
logic/flit_buffer.sv
logic/noc_port.sv
bench/noc_port_tb.sv

//--- Makefile
# Verilator flow for the tile network port
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module noc_port_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module noc_port_tb -o noc_port_sim
	./obj_dir/noc_port_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
